/* common/bk_pkg.sv */
// Backup RAM save engine shared widths and sector counts

package bk_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Disk host side
	////////////////////////////////////////////////////////////////////////////

	// Sector number as sent to the host
	localparam int lba_w = 32;

	// Word address inside one 512-byte sector
	localparam int buf_addr_w = 8;

	////////////////////////////////////////////////////////////////////////////
	// Internal backup RAM
	////////////////////////////////////////////////////////////////////////////

	// 8 KB split into host sectors
	localparam int bram_sectors = 16;

	// Selects one backup RAM sector
	localparam int bram_sect_w = 4;

	// Console byte address
	localparam int bram_byte_w = 13;

	////////////////////////////////////////////////////////////////////////////
	// Cartridge RAM path
	////////////////////////////////////////////////////////////////////////////

	// Byte offset within the staging buffer, one sector deep
	localparam int stage_byte_w = 9;

	// Cartridge sector index, goes in front of the byte offset
	// on the cartridge memory address
	localparam int cart_sect_w = 10;

endpackage

/* src/bram_dual_width.sv */
// Dual-port RAM with a byte port and a word port over one shared store

`timescale 1ns/10ps

module bram_dual_width #(
	parameter int addr_a_w = 13,
	parameter int addr_b_w = 12
) (
	input  logic                clk_sys,

	input  logic [addr_a_w-1:0] addr_a,
	input  logic [7:0]          data_a,
	input  logic                we_a,
	output logic [7:0]          q_a,

	input  logic [addr_b_w-1:0] addr_b,
	input  logic [15:0]         data_b,
	input  logic                we_b,
	output logic [15:0]         q_b
);

	// Byte storage, port B sees pairs of bytes
	logic [7:0] mem [0:(2**addr_a_w)-1];

	logic [addr_a_w-1:0] addr_b_lo;
	logic [addr_a_w-1:0] addr_b_hi;

	// Even byte goes in the low half of the word
	assign addr_b_lo = {addr_b, 1'b0};
	assign addr_b_hi = {addr_b, 1'b1};

	always_ff @(posedge clk_sys) begin
		if (we_a) begin
			mem[addr_a] <= data_a;
		end
		if (we_b) begin
			mem[addr_b_lo] <= data_b[7:0];
			mem[addr_b_hi] <= data_b[15:8];
		end

		// Registered reads, old data on a same-cycle write
		q_a <= mem[addr_a];
		q_b <= {mem[addr_b_hi], mem[addr_b_lo]};
	end

endmodule

/* sector_buffer/sector_buffer.sv */
// Backup RAM and staging buffer with host buffer port steering by sector

`timescale 1ns/10ps

module sector_buffer (
	input  logic                           clk_sys,

	input  logic [bk_pkg::bram_byte_w-1:0] bram_addr,
	input  logic [7:0]                     bram_wdata,
	input  logic                           bram_we,
	output logic [7:0]                     bram_rdata,

	input  logic [bk_pkg::lba_w-1:0]       sd_lba,
	input  logic                           sd_ack,
	input  logic [bk_pkg::buf_addr_w-1:0]  sd_buff_addr,
	input  logic [15:0]                    sd_buff_dout,
	input  logic                           sd_buff_wr,
	output logic [15:0]                    sd_buff_din,

	input  logic [bk_pkg::stage_byte_w-1:0] stage_addr,
	input  logic [7:0]                     stage_wdata,
	input  logic                           stage_we,
	output logic [7:0]                     stage_rdata
);
	import bk_pkg::*;

	logic        lba_is_bram;
	logic        host_wr;
	logic [15:0] bram_q_b;
	logic [15:0] stage_q_b;

	// First sectors map onto the backup RAM, the rest go to staging
	assign lba_is_bram = (sd_lba < lba_w'(bram_sectors));
	assign host_wr     = sd_buff_wr & sd_ack;

	// Sector select is stable over a transfer, so a plain mux on the
	// registered word outputs keeps the one cycle read latency
	assign sd_buff_din = lba_is_bram ? bram_q_b : stage_q_b;

	bram_dual_width #(
		.addr_a_w(bram_byte_w),
		.addr_b_w(bram_sect_w + buf_addr_w)
	) backup_ram (
		.clk_sys(clk_sys),
		.addr_a (bram_addr),
		.data_a (bram_wdata),
		.we_a   (bram_we),
		.q_a    (bram_rdata),
		.addr_b ({sd_lba[bram_sect_w-1:0], sd_buff_addr}),
		.data_b (sd_buff_dout),
		.we_b   (host_wr & lba_is_bram),
		.q_b    (bram_q_b)
	);

	bram_dual_width #(
		.addr_a_w(stage_byte_w),
		.addr_b_w(buf_addr_w)
	) stage_ram (
		.clk_sys(clk_sys),
		.addr_a (stage_addr),
		.data_a (stage_wdata),
		.we_a   (stage_we),
		.q_a    (stage_rdata),
		.addr_b (sd_buff_addr),
		.data_b (sd_buff_dout),
		.we_b   (host_wr & ~lba_is_bram),
		.q_b    (stage_q_b)
	);

endmodule

/* sector_buffer/stage_copier.sv */
// Byte-by-byte copy between the staging buffer and cartridge memory

`timescale 1ns/10ps

module stage_copier (
	input  logic                            clk_sys,
	input  logic                            rst_n,

	input  logic                            copy_start,
	input  logic                            copy_load,
	input  logic [bk_pkg::cart_sect_w-1:0]  cart_sector,
	output logic                            copy_done,

	output logic [bk_pkg::stage_byte_w-1:0] stage_addr,
	output logic [7:0]                      stage_wdata,
	output logic                            stage_we,
	input  logic [7:0]                      stage_rdata,

	output logic                            cart_req,
	output logic                            cart_we,
	output logic [bk_pkg::cart_sect_w+bk_pkg::stage_byte_w-1:0] cart_addr,
	output logic [15:0]                     cart_wdata,
	input  logic [15:0]                     cart_rdata,
	input  logic                            cart_busy
);
	import bk_pkg::*;

	localparam logic [1:0] c_idle  = 2'd0;
	localparam logic [1:0] c_issue = 2'd1;
	localparam logic [1:0] c_xfer  = 2'd2;
	localparam logic [1:0] c_done  = 2'd3;

	logic [1:0]              state;
	logic [stage_byte_w-1:0] offset;
	logic                    busy_d;
	logic                    busy_fall;

	assign busy_fall = busy_d & ~cart_busy;

	assign stage_addr = offset;
	assign cart_addr  = {cart_sector, offset};
	assign cart_we    = copy_load;

	// Cartridge side is 16 bits wide, byte goes in both halves
	assign cart_wdata  = {stage_rdata, stage_rdata};
	assign stage_wdata = cart_rdata[7:0];
	assign stage_we    = (state == c_xfer) & busy_fall & ~copy_load;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state     <= c_idle;
			offset    <= '0;
			busy_d    <= 1'b0;
			cart_req  <= 1'b0;
			copy_done <= 1'b0;
		end else begin
			busy_d <= cart_busy;

			// Request only needs to live until the memory takes it
			if (cart_busy) begin
				cart_req <= 1'b0;
			end

			case (state)
				c_idle: begin
					if (copy_start) begin
						offset <= '0;
						state  <= c_issue;
					end
				end
				// Staging byte settled one cycle after the offset moved
				c_issue: begin
					cart_req <= 1'b1;
					state    <= c_xfer;
				end
				c_xfer: begin
					if (busy_fall) begin
						if (&offset) begin
							copy_done <= 1'b1;
							state     <= c_done;
						end else begin
							offset <= offset + 1'b1;
							state  <= c_issue;
						end
					end
				end
				default: begin
					if (!copy_start) begin
						copy_done <= 1'b0;
						state     <= c_idle;
					end
				end
			endcase
		end
	end

endmodule

/* save_ctrl/save_trigger.sv */
// Save engine arming, unsaved change tracking and start request generation

`timescale 1ns/10ps

module save_trigger (
	input  logic clk_sys,
	input  logic rst_n,

	input  logic mount_window,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic load_req,
	input  logic save_req,
	input  logic autosave,
	input  logic osd_open,
	input  logic bram_we,
	input  logic cart_en,
	input  logic cart_write,
	input  logic busy,

	output logic start,
	output logic start_load,
	output logic armed,
	output logic save_pending
);

	logic window_d;
	logic load_d;
	logic save_d;
	logic osd_d;
	logic change;
	logic load_ev;
	logic save_ev;

	assign change = bram_we | (cart_en & cart_write);

	// End of the mount window always reloads from the image
	assign load_ev = (load_req & ~load_d) | (window_d & ~mount_window);
	assign save_ev = (save_req & ~save_d) |
		(osd_open & ~osd_d & autosave & save_pending);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			window_d     <= 1'b0;
			load_d       <= 1'b0;
			save_d       <= 1'b0;
			osd_d        <= 1'b0;
			armed        <= 1'b0;
			save_pending <= 1'b0;
			start        <= 1'b0;
			start_load   <= 1'b0;
		end else begin
			window_d <= mount_window;
			load_d   <= load_req;
			save_d   <= save_req;
			osd_d    <= osd_open;

			// New window disarms until a writable image shows up in it
			if (mount_window && !window_d) begin
				armed <= 1'b0;
			end
			if (mount_window && img_mounted && !img_readonly) begin
				armed <= 1'b1;
			end

			if (busy) begin
				save_pending <= 1'b0;
			end else if (change) begin
				save_pending <= 1'b1;
			end

			// Single cycle pulse, held off while the sequencer is working
			start <= 1'b0;
			if (armed && !busy && !start && (load_ev || save_ev)) begin
				start      <= 1'b1;
				start_load <= load_ev;
			end
		end
	end

endmodule

/* save_ctrl/save_sequencer.sv */
// Sector sequencer for backup RAM and cartridge RAM load and save

`timescale 1ns/10ps

module save_sequencer #(
	parameter int cart_sectors = 1024
) (
	input  logic                           clk_sys,
	input  logic                           rst_n,

	input  logic                           start,
	input  logic                           start_load,
	input  logic                           cart_en,

	input  logic                           sd_ack,
	output logic [bk_pkg::lba_w-1:0]       sd_lba,
	output logic                           sd_rd,
	output logic                           sd_wr,

	output logic                           busy,
	output logic                           reload,

	output logic                           copy_start,
	output logic                           copy_load,
	output logic [bk_pkg::cart_sect_w-1:0] cart_sector,
	input  logic                           copy_done
);
	import bk_pkg::*;

	localparam logic [2:0] s_idle    = 3'd0;
	localparam logic [2:0] s_bram    = 3'd1;
	localparam logic [2:0] s_ld_host = 3'd2;
	localparam logic [2:0] s_ld_copy = 3'd3;
	localparam logic [2:0] s_sv_copy = 3'd4;
	localparam logic [2:0] s_sv_host = 3'd5;

	localparam logic [lba_w-1:0] last_bram_lba = lba_w'(bram_sectors - 1);
	localparam logic [lba_w-1:0] last_cart_lba = lba_w'(bram_sectors + cart_sectors - 1);

	logic [2:0] state;
	logic       loading;
	logic       ack_d;
	logic       ack_fall;
	logic       last_cart;

	// Sector is finished on the falling edge of the host acknowledge
	assign ack_fall  = ack_d & ~sd_ack;
	assign last_cart = (sd_lba == last_cart_lba);

	assign copy_load   = loading;
	assign cart_sector = cart_sect_w'(sd_lba - lba_w'(bram_sectors));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state      <= s_idle;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			busy       <= 1'b0;
			reload     <= 1'b0;
			loading    <= 1'b0;
			ack_d      <= 1'b0;
			copy_start <= 1'b0;
		end else begin
			ack_d <= sd_ack;

			if (!ack_d && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				s_idle: begin
					if (start) begin
						busy    <= 1'b1;
						loading <= start_load;
						reload  <= start_load;
						sd_lba  <= '0;
						sd_rd   <= start_load;
						sd_wr   <= ~start_load;
						state   <= s_bram;
					end
				end

				////////////////////////////////////////////////////////////////////////
				// Backup RAM sectors go straight through the host buffer port
				////////////////////////////////////////////////////////////////////////
				s_bram: begin
					if (ack_fall) begin
						sd_lba <= sd_lba + 1'b1;
						if (sd_lba != last_bram_lba) begin
							sd_rd <= loading;
							sd_wr <= ~loading;
						end else if (!cart_en) begin
							busy   <= 1'b0;
							reload <= 1'b0;
							state  <= s_idle;
						end else if (loading) begin
							sd_rd <= 1'b1;
							state <= s_ld_host;
						end else begin
							copy_start <= 1'b1;
							state      <= s_sv_copy;
						end
					end
				end

				////////////////////////////////////////////////////////////////////////
				// Cartridge sectors pass through the staging buffer
				////////////////////////////////////////////////////////////////////////
				s_ld_host: begin
					if (ack_fall) begin
						copy_start <= 1'b1;
						state      <= s_ld_copy;
					end
				end
				s_ld_copy: begin
					if (copy_done) begin
						copy_start <= 1'b0;
						if (last_cart) begin
							busy   <= 1'b0;
							reload <= 1'b0;
							state  <= s_idle;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= 1'b1;
							state  <= s_ld_host;
						end
					end
				end
				// Save fills staging from the cartridge before the host write
				s_sv_copy: begin
					if (copy_done) begin
						copy_start <= 1'b0;
						sd_wr      <= 1'b1;
						state      <= s_sv_host;
					end
				end
				default: begin
					if (ack_fall) begin
						if (last_cart) begin
							busy  <= 1'b0;
							state <= s_idle;
						end else begin
							sd_lba     <= sd_lba + 1'b1;
							copy_start <= 1'b1;
							state      <= s_sv_copy;
						end
					end
				end
			endcase
		end
	end

endmodule

/* src/bk_top.sv */
// Backup RAM save and load engine top level

`timescale 1ns/10ps

module bk_top #(
	parameter int cart_sectors = 1024
) (
	input  logic                           clk_sys,
	input  logic                           rst_n,

	// Image mount and menu controls
	input  logic                           mount_window,
	input  logic                           img_mounted,
	input  logic                           img_readonly,
	input  logic                           load_req,
	input  logic                           save_req,
	input  logic                           autosave,
	input  logic                           osd_open,
	input  logic                           cart_en,
	input  logic                           cart_write,
	output logic                           armed,
	output logic                           save_pending,
	output logic                           busy,
	output logic                           reload,

	// Console byte port
	input  logic [bk_pkg::bram_byte_w-1:0] bram_addr,
	input  logic [7:0]                     bram_wdata,
	input  logic                           bram_we,
	output logic [7:0]                     bram_rdata,

	// Disk host
	output logic [bk_pkg::lba_w-1:0]       sd_lba,
	output logic                           sd_rd,
	output logic                           sd_wr,
	input  logic                           sd_ack,
	input  logic [bk_pkg::buf_addr_w-1:0]  sd_buff_addr,
	input  logic [15:0]                    sd_buff_dout,
	input  logic                           sd_buff_wr,
	output logic [15:0]                    sd_buff_din,

	// Cartridge memory
	output logic                           cart_req,
	output logic                           cart_we,
	output logic [bk_pkg::cart_sect_w+bk_pkg::stage_byte_w-1:0] cart_addr,
	output logic [15:0]                    cart_wdata,
	input  logic [15:0]                    cart_rdata,
	input  logic                           cart_busy
);
	import bk_pkg::*;

	logic                    start;
	logic                    start_load;
	logic                    copy_start;
	logic                    copy_load;
	logic                    copy_done;
	logic [cart_sect_w-1:0]  cart_sector;
	logic [stage_byte_w-1:0] stage_addr;
	logic [7:0]              stage_wdata;
	logic                    stage_we;
	logic [7:0]              stage_rdata;

	sector_buffer sector_buffer (.*);

	stage_copier stage_copier (.*);

	save_trigger save_trigger (.*);

	save_sequencer #(
		.cart_sectors(cart_sectors)
	) save_sequencer (.*);

endmodule

/* bench/cart_mem_model.sv */
// Cartridge memory model with a random busy time on every access

`timescale 1ns/10ps

module cart_mem_model #(
	parameter int depth = 1024
) (
	input  logic                            clk_sys,
	input  logic                            cart_req,
	input  logic                            cart_we,
	input  logic [bk_pkg::cart_sect_w+bk_pkg::stage_byte_w-1:0] cart_addr,
	input  logic [15:0]                     cart_wdata,
	output logic [15:0]                     cart_rdata,
	output logic                            cart_busy
);
	import bk_pkg::*;

	// Byte store, only the low half of a write word is kept
	logic [7:0] mem [0:depth-1];

	logic        busy_r  = 1'b0;
	logic [15:0] rdata_r = 16'h0000;
	int          wait_cnt = 0;

	assign cart_busy  = busy_r;
	assign cart_rdata = rdata_r;

	always @(posedge clk_sys) begin
		if (busy_r) begin
			if (wait_cnt == 0) begin
				busy_r <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end else if (cart_req) begin
			// Access done at once, busy only stretches the handshake
			busy_r   <= 1'b1;
			wait_cnt <= $urandom_range(3);
			if (cart_we) begin
				mem[int'(cart_addr) % depth] <= cart_wdata[7:0];
			end else begin
				rdata_r <= {mem[int'(cart_addr) % depth], mem[int'(cart_addr) % depth]};
			end
		end
	end

endmodule

/* bench/tb_bk_top.sv */
// Testbench for the backup RAM save engine with disk host and cartridge models

`timescale 1ns/10ps

module tb_bk_top;
	import bk_pkg::*;

	localparam int req_timeout  = 8000;
	localparam int idle_timeout = 8000;
	localparam int quiet_cycles = 60;

	logic clk_sys;
	logic rst_n;
	logic mount_window;
	logic img_mounted;
	logic img_readonly;
	logic load_req;
	logic save_req;
	logic autosave;
	logic osd_open;
	logic cart_en;
	logic cart_write;
	logic armed;
	logic save_pending;
	logic busy;
	logic reload;
	logic [bram_byte_w-1:0] bram_addr;
	logic [7:0]             bram_wdata;
	logic                   bram_we;
	logic [7:0]             bram_rdata;
	logic [lba_w-1:0]       sd_lba;
	logic                   sd_rd;
	logic                   sd_wr;
	logic                   sd_ack;
	logic [buf_addr_w-1:0]  sd_buff_addr;
	logic [15:0]            sd_buff_dout;
	logic                   sd_buff_wr;
	logic [15:0]            sd_buff_din;
	logic                   cart_req;
	logic                   cart_we;
	logic [cart_sect_w+stage_byte_w-1:0] cart_addr;
	logic [15:0]            cart_wdata;
	logic [15:0]            cart_rdata;
	logic                   cart_busy;

	// Expected image, LBA 0 to 17 back to back, 512 bytes each
	logic [7:0] img_exp [0:18*512-1];

	int chk_cnt  = 0;
	int err_cnt  = 0;
	int fail_cnt = 0;

	bk_top #(
		.cart_sectors(2)
	) dut0 (.*);

	cart_mem_model cart0 (.*);

	always #2 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_bit(input string name, input logic exp, input logic got);
		chk_cnt++;
		if (got !== exp) begin
			$display("ERR %0t %s expected %b got %b", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
		chk_cnt++;
		if (got !== exp) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] exp,
		input logic [15:0] got);
		chk_cnt++;
		if (got !== exp) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_lba(input string name, input logic [lba_w-1:0] exp,
		input logic [lba_w-1:0] got);
		chk_cnt++;
		if (got !== exp) begin
			$display("ERR %0t %s expected %0d got %0d", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	// Cartridge writes carry the staged host byte in both halves
	always @(negedge clk_sys) begin
		if (rst_n && cart_req && cart_we) begin
			check_word("cart_wdata",
				{2{img_exp[bram_sectors * 512 + int'(cart_addr)]}}, cart_wdata);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Disk host, console and wait helpers
	////////////////////////////////////////////////////////////////////////////

	// Answers one sector request, load writes random words, save checks them
	task automatic serve_sector(input logic load, input int lba);
		int t;
		int k;
		int base;
		logic [15:0] w;
		t = 0;
		base = lba * 512;
		while (!(sd_rd || sd_wr) && t < req_timeout) begin
			@(negedge clk_sys);
			t++;
		end
		if (!(sd_rd || sd_wr)) begin
			$display("Timeout: no disk request arrived for sector %0d", lba);
			fail_cnt++;
			return;
		end
		check_bit("sd_rd", load, sd_rd);
		check_bit("sd_wr", ~load, sd_wr);
		check_lba("sd_lba", lba_w'(lba), sd_lba);
		sd_ack = 1'b1;
		if (load) begin
			for (k = 0; k < 256; k++) begin
				w = 16'($urandom);
				sd_buff_addr = buf_addr_w'(k);
				sd_buff_dout = w;
				sd_buff_wr   = 1'b1;
				img_exp[base + 2 * k]     = w[7:0];
				img_exp[base + 2 * k + 1] = w[15:8];
				@(negedge clk_sys);
			end
			sd_buff_wr = 1'b0;
		end else begin
			// Read data trails the address by one cycle
			for (k = 0; k <= 256; k++) begin
				if (k > 0) begin
					check_word("sd_buff_din", {img_exp[base + 2 * k - 1],
						img_exp[base + 2 * k - 2]}, sd_buff_din);
				end
				if (k < 256) begin
					sd_buff_addr = buf_addr_w'(k);
				end
				@(negedge clk_sys);
			end
		end
		sd_ack = 1'b0;
	endtask

	task automatic serve_range(input logic load, input int first, input int last);
		int lba;
		for (lba = first; lba <= last; lba++) begin
			serve_sector(load, lba);
		end
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		while (busy && t < idle_timeout) begin
			@(negedge clk_sys);
			t++;
		end
		if (busy) begin
			$display("Timeout: operation did not finish, busy stayed high");
			fail_cnt++;
		end
	endtask

	task automatic expect_quiet(input string what);
		int t;
		logic seen;
		seen = 1'b0;
		chk_cnt++;
		for (t = 0; t < quiet_cycles; t++) begin
			if (busy || sd_rd || sd_wr) begin
				seen = 1'b1;
			end
			@(negedge clk_sys);
		end
		if (seen) begin
			$display("%s started an operation but should have been ignored", what);
			fail_cnt++;
		end
	endtask

	task automatic write_byte(input logic [bram_byte_w-1:0] a, input logic [7:0] d);
		bram_addr  = a;
		bram_wdata = d;
		bram_we    = 1'b1;
		img_exp[int'(a)] = d;
		@(negedge clk_sys);
		bram_we = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_idle();
		check_bit("sd_rd", 1'b0, sd_rd);
		check_bit("sd_wr", 1'b0, sd_wr);
		check_bit("busy", 1'b0, busy);
		check_bit("reload", 1'b0, reload);
		check_bit("save_pending", 1'b0, save_pending);
		check_bit("cart_req", 1'b0, cart_req);
		check_bit("armed", 1'b0, armed);
		load_req = 1'b1;
		@(negedge clk_sys);
		load_req = 1'b0;
		expect_quiet("load_req without a mounted image");
	endtask

	task automatic test_mount_load();
		int a;
		mount_window = 1'b1;
		repeat (3) @(negedge clk_sys);
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		@(negedge clk_sys);
		check_bit("armed", 1'b1, armed);
		// Closing the window loads the whole backup RAM
		mount_window = 1'b0;
		serve_range(1'b1, 0, bram_sectors - 1);
		wait_idle();
		for (a = 0; a < 2 ** bram_byte_w; a++) begin
			bram_addr = bram_byte_w'(a);
			@(negedge clk_sys);
			check_byte("bram_rdata", img_exp[a], bram_rdata);
		end
	endtask

	task automatic test_console_save();
		write_byte(13'h0a37, ~img_exp[13'h0a37]);
		check_bit("save_pending", 1'b1, save_pending);
		save_req = 1'b1;
		@(negedge clk_sys);
		save_req = 1'b0;
		serve_range(1'b0, 0, bram_sectors - 1);
		wait_idle();
		check_bit("save_pending", 1'b0, save_pending);
	endtask

	task automatic test_autosave();
		autosave = 1'b1;
		check_bit("save_pending", 1'b0, save_pending);
		osd_open = 1'b1;
		expect_quiet("Menu open with nothing to save");
		osd_open = 1'b0;
		write_byte(13'h1ffe, 8'h3c);
		osd_open = 1'b1;
		serve_range(1'b0, 0, bram_sectors - 1);
		wait_idle();
		check_bit("save_pending", 1'b0, save_pending);
		osd_open = 1'b0;
		autosave = 1'b0;
	endtask

	task automatic test_cart_copy();
		int i;
		cart_en    = 1'b1;
		cart_write = 1'b1;
		@(negedge clk_sys);
		cart_write = 1'b0;
		@(negedge clk_sys);
		check_bit("save_pending", 1'b1, save_pending);
		load_req = 1'b1;
		@(negedge clk_sys);
		load_req = 1'b0;
		serve_sector(1'b1, 0);
		check_bit("reload", 1'b1, reload);
		serve_range(1'b1, 1, bram_sectors + 1);
		wait_idle();
		check_bit("reload", 1'b0, reload);
		for (i = 0; i < 1024; i++) begin
			check_byte("cart mem", img_exp[bram_sectors * 512 + i], cart0.mem[i]);
		end
		// Save brings the cartridge bytes back through staging
		save_req = 1'b1;
		@(negedge clk_sys);
		save_req = 1'b0;
		serve_range(1'b0, 0, bram_sectors + 1);
		wait_idle();
		cart_en = 1'b0;
	endtask

	task automatic test_readonly_image();
		mount_window = 1'b1;
		repeat (2) @(negedge clk_sys);
		img_mounted  = 1'b1;
		img_readonly = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		@(negedge clk_sys);
		mount_window = 1'b0;
		expect_quiet("End of a read-only mount window");
		check_bit("armed", 1'b0, armed);
		load_req = 1'b1;
		@(negedge clk_sys);
		load_req = 1'b0;
		expect_quiet("load_req on a read-only image");
		write_byte(13'h0100, 8'ha5);
		save_req = 1'b1;
		@(negedge clk_sys);
		save_req = 1'b0;
		expect_quiet("save_req on a read-only image");
		img_readonly = 1'b0;
	endtask

	initial begin
		void'($urandom(41822));
		clk_sys      = 1'b0;
		rst_n        = 1'b0;
		mount_window = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		autosave     = 1'b0;
		osd_open     = 1'b0;
		cart_en      = 1'b0;
		cart_write   = 1'b0;
		bram_addr    = '0;
		bram_wdata   = '0;
		bram_we      = 1'b0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		repeat (8) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);

		test_reset_idle();
		test_mount_load();
		test_console_save();
		test_autosave();
		test_cart_copy();
		test_readonly_image();

		$display("Checks %0d, value errors %0d, other failures %0d",
			chk_cnt, err_cnt, fail_cnt);
		if (err_cnt == 0 && fail_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* filelist.f */
common/bk_pkg.sv
src/bram_dual_width.sv
sector_buffer/sector_buffer.sv
sector_buffer/stage_copier.sv
save_ctrl/save_trigger.sv
save_ctrl/save_sequencer.sv
src/bk_top.sv
bench/cart_mem_model.sv
bench/tb_bk_top.sv
